// File: coarse_window.sv
/* RANGE_LIMIT must be at least 2 and below 2**COARSE_BIT.
   a start outside idle is dropped, the core stays busy until the burst ends */
`default_nettype none

module coarse_window #(
    parameter int RANGE_LIMIT = tdc_cfg_pkg::DEFAULT_RANGE
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire tdc_types_pkg::phase_event_t    evt,
    input  wire                                 burst_done,
    output logic [tdc_cfg_pkg::COARSE_BIT-1:0]  coarse,
    output logic                                window_open,
    output logic                                window_done,
    output logic                                busy
);
    import tdc_cfg_pkg::*;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_MEASURE,
        WIN_HOLD
    } win_state_t;

    localparam logic [COARSE_BIT-1:0] LAST_COUNT = COARSE_BIT'(RANGE_LIMIT - 1);

    win_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= WIN_IDLE;
            coarse      <= '0;
            window_done <= 1'b0;
            busy        <= 1'b0;
        end else begin
            window_done <= 1'b0;
            case (state)
                WIN_IDLE: begin
                    if (evt.start) begin
                        state  <= WIN_MEASURE;
                        coarse <= COARSE_BIT'(1);   // start cycle was count 0
                        busy   <= 1'b1;
                    end else begin
                        coarse <= '0;
                    end
                end
                WIN_MEASURE: begin
                    coarse <= coarse + 1'b1;
                    if (coarse == LAST_COUNT) begin
                        state       <= WIN_HOLD;
                        window_done <= 1'b1;        // high while coarse == RANGE_LIMIT
                    end
                end
                WIN_HOLD: begin
                    // count holds at RANGE_LIMIT during calc and readout
                    if (burst_done) begin
                        state  <= WIN_IDLE;
                        coarse <= '0;
                        busy   <= 1'b0;
                    end
                end
                default: state <= WIN_IDLE;
            endcase
        end
    end

    // open window means count is 1..RANGE_LIMIT-1
    assign window_open = (state == WIN_MEASURE);

endmodule : coarse_window

`default_nettype wire

// File: hit_recorder.sv
/* hits past MAX_HITS are dropped, the store keeps the first ones.
   store contents are only meaningful below hit_count */
`default_nettype none

module hit_recorder #(
    parameter int MAX_HITS = tdc_cfg_pkg::DEFAULT_MAX_HITS
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire tdc_types_pkg::phase_event_t    evt,
    input  wire [tdc_cfg_pkg::COARSE_BIT-1:0]   coarse,
    input  wire                                 window_open,
    input  wire [tdc_cfg_pkg::NUM_BIT-1:0]      rd_index,
    output tdc_types_pkg::hit_t                 hit,
    output logic [tdc_cfg_pkg::FINE_BIT-1:0]    start_fine,
    output logic [tdc_cfg_pkg::NUM_BIT-1:0]     hit_count
);
    import tdc_cfg_pkg::*;
    import tdc_types_pkg::*;

    localparam logic [NUM_BIT-1:0] DEPTH = NUM_BIT'(MAX_HITS);

    hit_t hit_mem [MAX_HITS];
    logic start_ok;
    logic hit_ok;

    // idle is the only state with a closed window and a zero count,
    // so a start while busy never reaches here
    assign start_ok = evt.start & ~window_open & (coarse == '0);
    assign hit_ok   = evt.hit & window_open & (hit_count < DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_fine <= '0;
            hit_count  <= '0;
        end else if (start_ok) begin
            start_fine <= evt.fine;
            hit_count  <= '0;          // new measurement
        end else if (hit_ok) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    // append at the current count
    always_ff @(posedge clk) begin
        if (hit_ok) begin
            hit_mem[hit_count] <= '{coarse: coarse, fine: evt.fine};
        end
    end

    assign hit = hit_mem[rd_index];

endmodule : hit_recorder

`default_nettype wire

// File: list.f
tdc_cfg_pkg.sv
tdc_types_pkg.sv
phase_sampler.sv
coarse_window.sv
hit_recorder.sv
tof_calc.sv
readout_fsm.sv
tdc_top.sv
tb_tdc_top.sv

// File: phase_sampler.sv
/* strobes must already be synchronous to clk.
   dll_phase is a thermometer code filled from bit 0 */
`default_nettype none

module phase_sampler (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire [tdc_cfg_pkg::PHASE_BIT-1:0]    dll_phase,
    input  wire                                 tdc_start,
    input  wire                                 tdc_trigger,
    output tdc_types_pkg::phase_event_t         evt
);
    import tdc_cfg_pkg::*;

    logic                 start_q;
    logic                 start_qq;
    logic                 trig_q;
    logic                 trig_qq;
    logic [PHASE_BIT-1:0] phase_q;     // taken with the strobe sample

    // thermometer to binary by counting the ones
    function automatic logic [FINE_BIT-1:0] count_ones(input logic [PHASE_BIT-1:0] therm);
        logic [FINE_BIT-1:0] n;
        n = '0;
        for (int i = 0; i < PHASE_BIT; i++) begin
            n = n + FINE_BIT'(therm[i]);
        end
        return n;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q  <= 1'b0;
            start_qq <= 1'b0;
            trig_q   <= 1'b0;
            trig_qq  <= 1'b0;
            phase_q  <= '0;
        end else begin
            start_q  <= tdc_start;
            start_qq <= start_q;
            trig_q   <= tdc_trigger;
            trig_qq  <= trig_q;
            phase_q  <= dll_phase;
        end
    end

    // pulses last the one cycle after the first edge that sees the strobe high
    always_comb begin
        evt.start = start_q & ~start_qq;
        evt.hit   = trig_q & ~trig_qq;
        evt.fine  = count_ones(phase_q);
    end

endmodule : phase_sampler

`default_nettype wire

// File: readout_fsm.sv
/* tdc_ready is only checked before a burst, a started burst runs to the end.
   tdc_out reads 0 whenever tdc_valid is low */
`default_nettype none

module readout_fsm #(
    parameter int MAX_HITS = tdc_cfg_pkg::DEFAULT_MAX_HITS
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 calc_done,
    input  wire [tdc_cfg_pkg::NUM_BIT-1:0]      hit_count,
    input  wire                                 tdc_ready,
    output logic [tdc_cfg_pkg::NUM_BIT-1:0]     res_index,
    input  wire [tdc_cfg_pkg::TOF_BIT-1:0]      result,
    output tdc_types_pkg::tof_word_t            tdc_out,
    output logic                                tdc_valid,
    output logic                                burst_done
);
    import tdc_cfg_pkg::*;
    import tdc_types_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_READY,
        RD_SEND
    } rd_state_t;

    localparam logic [NUM_BIT-1:0] DEPTH = NUM_BIT'(MAX_HITS);

    rd_state_t          state;
    logic [NUM_BIT-1:0] burst_len;     // 0 means the no-hit word
    logic [NUM_BIT-1:0] next_index;
    logic               start_burst;
    logic               word_last;
    tof_word_t          word;

    // keeps res_index inside the result store
    assign burst_len = (hit_count > DEPTH) ? DEPTH : hit_count;

    // ready may already be high on the calc_done cycle
    assign start_burst = tdc_ready
                       & (((state == RD_IDLE) & calc_done) | (state == RD_WAIT_READY));

    assign next_index = res_index + 1'b1;
    assign word_last  = (next_index >= burst_len);   // also true for the empty burst

    //==========================================================================
    // next output word, built from the slot at res_index
    //==========================================================================
    always_comb begin
        word.data = (burst_len == '0) ? NO_HIT_CODE : result;
        word.num  = burst_len;
        word.last = word_last;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RD_IDLE;
            res_index <= '0;
            tdc_out   <= '0;
            tdc_valid <= 1'b0;
        end else begin
            case (state)
                RD_IDLE, RD_WAIT_READY: begin
                    if (start_burst) begin
                        state     <= RD_SEND;
                        tdc_out   <= word;
                        tdc_valid <= 1'b1;
                        res_index <= next_index;
                    end else if (calc_done) begin
                        state <= RD_WAIT_READY;
                    end
                end
                RD_SEND: begin
                    if (tdc_out.last) begin
                        state     <= RD_IDLE;
                        res_index <= '0;
                        tdc_out   <= '0;
                        tdc_valid <= 1'b0;
                    end else begin
                        tdc_out   <= word;        // one word per cycle
                        res_index <= next_index;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // high with the final word so busy drops when tdc_valid does
    assign burst_done = (state == RD_SEND) & tdc_out.last;

endmodule : readout_fsm

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# the exit status is the simulator's, nonzero on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tdc_top -f list.f -o tb_tdc_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_tdc_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0

// File: tb_tdc_top.sv
/* runs the core with RANGE_LIMIT 60 and MAX_HITS 5. strobe offsets in one row
   must be at least 2 cycles apart, or two strobes merge into one rising edge */
`default_nettype none

module tb_tdc_top;
    import tdc_cfg_pkg::*;
    import tdc_types_pkg::*;

    localparam int RANGE      = 60;
    localparam int HITS       = 5;
    localparam int NUM_ROWS   = 7;
    localparam int MAX_TRIG   = 8;
    localparam int DRIVE_DLY  = 2;
    localparam int VALID_WAIT = 200;   // cycles

    logic                 clk;
    logic                 rst_n;
    logic [PHASE_BIT-1:0] dll_phase;
    logic                 tdc_start;
    logic                 tdc_trigger;
    logic                 tdc_ready;
    tof_word_t            tdc_out;
    logic                 tdc_valid;
    logic                 busy;

    // levels are fine codes 0..16, -1 draws a random one
    int start_lvl   [NUM_ROWS];
    int extra_start [NUM_ROWS];   // offset of a start while busy, 0 for none
    int ready_at    [NUM_ROWS];   // offset where tdc_ready goes high
    int exp_num     [NUM_ROWS];
    int n_trig      [NUM_ROWS];
    int trig_off    [NUM_ROWS][MAX_TRIG];
    int trig_lvl    [NUM_ROWS][MAX_TRIG];

    int          exp_tof [$];
    logic [31:0] rng;

    tdc_top #(.MAX_HITS(HITS), .RANGE_LIMIT(RANGE)) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .dll_phase   (dll_phase),
        .tdc_start   (tdc_start),
        .tdc_trigger (tdc_trigger),
        .tdc_ready   (tdc_ready),
        .tdc_out     (tdc_out),
        .tdc_valid   (tdc_valid),
        .busy        (busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //==========================================================================
    // helpers
    //==========================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lvl ones filled from bit 0
    function automatic logic [PHASE_BIT-1:0] therm(input int lvl);
        logic [31:0] w;
        w = (32'h1 << lvl) - 32'h1;
        return w[PHASE_BIT-1:0];
    endfunction

    task automatic pick_level(output int lvl);
        rng = xorshift(rng);
        lvl = int'(rng % 32'd17);
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s (time %0t)", msg, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    //==========================================================================
    // stimulus table
    //==========================================================================
    task automatic set_row(input int r, input int s_lvl, input int extra,
                           input int rdy, input int num);
        int lvl;
        lvl = s_lvl;
        if (lvl < 0) begin
            pick_level(lvl);
        end
        start_lvl[r]   = lvl;
        extra_start[r] = extra;
        ready_at[r]    = rdy;
        exp_num[r]     = num;
        n_trig[r]      = 0;
    endtask

    task automatic set_trig(input int r, input int off, input int t_lvl);
        int lvl;
        lvl = t_lvl;
        if (lvl < 0) begin
            pick_level(lvl);
        end
        trig_off[r][n_trig[r]] = off;
        trig_lvl[r][n_trig[r]] = lvl;
        n_trig[r]              = n_trig[r] + 1;
    endtask

    task automatic load_table();
        //      row start extra ready num
        set_row(0,  3,    0,    0,   1);   // single hit
        set_trig(0, 12, 9);
        set_row(1, 10,    0,    0,   3);   // three hits in order
        set_trig(1,  5, 0);
        set_trig(1, 17, 16);
        set_trig(1, 33, 7);
        set_row(2, -1,    0,    0,   5);   // seven triggers, first five kept
        set_trig(2,  3, -1);
        set_trig(2,  8, -1);
        set_trig(2, 14, -1);
        set_trig(2, 21, -1);
        set_trig(2, 27, -1);
        set_trig(2, 40, -1);
        set_trig(2, 52, -1);
        set_row(3,  6,    0,    0,   0);   // empty window
        set_row(4, -1,   30,   75,   1);   // late trigger, start while busy
        set_trig(4, 20, -1);
        set_trig(4, 70, -1);
        set_row(5, -1,    0,   80,   2);   // window edges, ready held low
        set_trig(5,  1, -1);
        set_trig(5, 59, -1);
        set_trig(5, 61, -1);
        set_row(6, 16,    0,    0,   1);   // start fine above stop fine
        set_trig(6,  2, 0);
    endtask

    // tof = offset * 16 + stop fine - start fine, first HITS inside the window
    task automatic build_expected(input int r);
        int count;
        int i;
        count = 0;
        exp_tof.delete();
        for (i = 0; i < n_trig[r]; i++) begin
            if (trig_off[r][i] >= 1 && trig_off[r][i] <= RANGE - 1 && count < HITS) begin
                exp_tof.push_back(trig_off[r][i] * 16 + trig_lvl[r][i] - start_lvl[r]);
                count++;
            end
        end
    endtask

    //==========================================================================
    // one measurement
    //==========================================================================
    task automatic run_row(input int r);
        int   last_t;
        int   waited;
        int   n_words;
        int   lvl;
        int   t;
        int   i;
        int   k;
        logic trig_now;
        logic [31:0] exp_data;

        build_expected(r);
        $display("row %0d: %0d trigger(s), %0d result(s) expected",
                 r, n_trig[r], exp_tof.size());

        last_t = (ready_at[r] > 1) ? ready_at[r] : 1;
        if (extra_start[r] + 1 > last_t) begin
            last_t = extra_start[r] + 1;
        end
        for (i = 0; i < n_trig[r]; i++) begin
            if (trig_off[r][i] + 1 > last_t) begin
                last_t = trig_off[r][i] + 1;
            end
        end

        for (t = 0; t <= last_t; t++) begin
            trig_now = 1'b0;
            pick_level(lvl);                   // noise phase between strobes
            for (i = 0; i < n_trig[r]; i++) begin
                if (trig_off[r][i] == t) begin
                    trig_now = 1'b1;
                    lvl      = trig_lvl[r][i];
                end
            end
            if (t == 0) begin
                lvl = start_lvl[r];
            end else if (extra_start[r] != 0 && t == extra_start[r]) begin
                lvl = (start_lvl[r] + 5) % 17;  // must not replace start fine
            end
            tdc_start   = (t == 0) || (extra_start[r] != 0 && t == extra_start[r]);
            tdc_trigger = trig_now;
            tdc_ready   = (t >= ready_at[r]);
            dll_phase   = therm(lvl);
            check_val("busy", 32'(busy), (t >= 2) ? 32'd1 : 32'd0);
            check_val("tdc_valid", 32'(tdc_valid), 32'd0);
            step();
        end

        tdc_start   = 1'b0;
        tdc_trigger = 1'b0;
        tdc_ready   = 1'b1;
        waited      = 0;
        while (tdc_valid !== 1'b1) begin
            if (waited >= VALID_WAIT) begin
                fail_run("timeout: tdc_valid never rose after the measurement window");
            end
            check_val("busy", 32'(busy), 32'd1);
            step();
            waited++;
        end
        // ready came late, so valid must follow on the very next edge
        if (ready_at[r] > RANGE + HITS + 1) begin
            check_val("cycles from tdc_ready to tdc_valid", 32'(waited), 32'd0);
        end

        n_words = (exp_tof.size() == 0) ? 1 : exp_tof.size();
        for (k = 0; k < n_words; k++) begin
            if (exp_tof.size() == 0) begin
                exp_data = (32'h1 << TOF_BIT) - 32'h1;   // all ones over the word
            end else begin
                exp_data = 32'(exp_tof[k]);
            end
            check_val("tdc_valid", 32'(tdc_valid), 32'd1);
            check_val("busy", 32'(busy), 32'd1);
            check_val("tdc_out.data", 32'(tdc_out.data), exp_data);
            check_val("tdc_out.num", 32'(tdc_out.num), 32'(exp_num[r]));
            check_val("tdc_out.last", 32'(tdc_out.last), (k == n_words - 1) ? 32'd1 : 32'd0);
            step();
        end

        check_val("tdc_valid", 32'(tdc_valid), 32'd0);
        check_val("busy", 32'(busy), 32'd0);
        check_val("tdc_out", 32'(tdc_out), 32'd0);  // zero while not valid
    endtask

    initial begin
        rng         = 32'd10;
        rst_n       = 1'b0;
        dll_phase   = '0;
        tdc_start   = 1'b0;
        tdc_trigger = 1'b0;
        tdc_ready   = 1'b0;
        load_table();

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        check_val("busy", 32'(busy), 32'd0);
        check_val("tdc_valid", 32'(tdc_valid), 32'd0);
        check_val("tdc_out", 32'(tdc_out), 32'd0);
        rst_n = 1'b1;
        step();
        check_val("busy", 32'(busy), 32'd0);
        check_val("tdc_valid", 32'(tdc_valid), 32'd0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
            repeat (3) step();          // idle gap between measurements
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule : tb_tdc_top

`default_nettype wire

// File: tdc_cfg_pkg.sv
/* all widths assume a 16-tap DLL and a 14-bit coarse counter.
   the hit count is 3 bits, so MAX_HITS must stay at 7 or below */
`default_nettype none

package tdc_cfg_pkg;

    //==========================================================================
    // datapath widths
    //==========================================================================
    localparam int PHASE_BIT  = 16;    // dll taps, one fine step each
    localparam int FINE_BIT   = 5;     // 0..16 ones in the phase word
    localparam int COARSE_BIT = 14;
    localparam int TOF_BIT    = 19;    // coarse * 16 + fine
    localparam int NUM_BIT    = 3;     // hits per measurement

    //==========================================================================
    // measurement defaults
    //==========================================================================
    localparam int DEFAULT_MAX_HITS = 5;
    localparam int DEFAULT_RANGE    = 10000;   // 3 km range in coarse counts

    // sent as the single burst word when the window saw no hit
    localparam logic [TOF_BIT-1:0] NO_HIT_CODE = '1;

endpackage : tdc_cfg_pkg

`default_nettype wire

// File: tdc_top.sv
/* single clock TDC core, strobes are sampled on clk and must be synchronous.
   MAX_HITS up to 7, RANGE_LIMIT from 2 to 2**COARSE_BIT-1 */
`default_nettype none

module tdc_top #(
    parameter int MAX_HITS    = tdc_cfg_pkg::DEFAULT_MAX_HITS,
    parameter int RANGE_LIMIT = tdc_cfg_pkg::DEFAULT_RANGE
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire [tdc_cfg_pkg::PHASE_BIT-1:0]    dll_phase,
    input  wire                                 tdc_start,
    input  wire                                 tdc_trigger,
    input  wire                                 tdc_ready,
    output tdc_types_pkg::tof_word_t            tdc_out,
    output logic                                tdc_valid,
    output logic                                busy
);
    import tdc_cfg_pkg::*;
    import tdc_types_pkg::*;

    phase_event_t          evt;
    hit_t                  hit;
    logic [COARSE_BIT-1:0] coarse;
    logic                  window_open;
    logic                  window_done;
    logic                  calc_done;
    logic                  burst_done;
    logic [FINE_BIT-1:0]   start_fine;
    logic [NUM_BIT-1:0]    hit_count;
    logic [NUM_BIT-1:0]    hit_index;
    logic [NUM_BIT-1:0]    res_index;
    logic [TOF_BIT-1:0]    result;

    //==========================================================================
    // capture side
    //==========================================================================
    phase_sampler u_sampler (
        .clk         (clk),
        .rst_n       (rst_n),
        .dll_phase   (dll_phase),
        .tdc_start   (tdc_start),
        .tdc_trigger (tdc_trigger),
        .evt         (evt)
    );

    coarse_window #(.RANGE_LIMIT(RANGE_LIMIT)) u_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .evt         (evt),
        .burst_done  (burst_done),
        .coarse      (coarse),
        .window_open (window_open),
        .window_done (window_done),
        .busy        (busy)
    );

    hit_recorder #(.MAX_HITS(MAX_HITS)) u_hits (
        .clk         (clk),
        .rst_n       (rst_n),
        .evt         (evt),
        .coarse      (coarse),
        .window_open (window_open),
        .rd_index    (hit_index),
        .hit         (hit),
        .start_fine  (start_fine),
        .hit_count   (hit_count)
    );

    //==========================================================================
    // calc and readout
    //==========================================================================
    tof_calc #(.MAX_HITS(MAX_HITS)) u_calc (
        .clk         (clk),
        .rst_n       (rst_n),
        .window_done (window_done),
        .hit_count   (hit_count),
        .hit         (hit),
        .start_fine  (start_fine),
        .hit_index   (hit_index),
        .res_index   (res_index),
        .result      (result),
        .calc_done   (calc_done)
    );

    readout_fsm #(.MAX_HITS(MAX_HITS)) u_readout (
        .clk         (clk),
        .rst_n       (rst_n),
        .calc_done   (calc_done),
        .hit_count   (hit_count),
        .tdc_ready   (tdc_ready),
        .res_index   (res_index),
        .result      (result),
        .tdc_out     (tdc_out),
        .tdc_valid   (tdc_valid),
        .burst_done  (burst_done)
    );

endmodule : tdc_top

`default_nettype wire

// File: tdc_types_pkg.sv
/* field order is part of the interface, tof_word_t is the output word */
`default_nettype none

package tdc_types_pkg;

    import tdc_cfg_pkg::*;

    // strobe edges seen in one cycle, fine code from the same sample
    typedef struct packed {
        logic                start;
        logic                hit;
        logic [FINE_BIT-1:0] fine;
    } phase_event_t;

    // one stored stop
    typedef struct packed {
        logic [COARSE_BIT-1:0] coarse;  // clk cycles since start
        logic [FINE_BIT-1:0]   fine;
    } hit_t;

    // burst word on the output
    typedef struct packed {
        logic [TOF_BIT-1:0] data;
        logic [NUM_BIT-1:0] num;    // words in this burst, 0 for no hit
        logic               last;
    } tof_word_t;

endpackage : tdc_types_pkg

`default_nettype wire

// File: tof_calc.sv
/* one hit per cycle, results stay valid until the next window_done.
   hit_count must be stable from window_done until calc_done */
`default_nettype none

module tof_calc #(
    parameter int MAX_HITS = tdc_cfg_pkg::DEFAULT_MAX_HITS
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 window_done,
    input  wire [tdc_cfg_pkg::NUM_BIT-1:0]      hit_count,
    input  wire tdc_types_pkg::hit_t            hit,
    input  wire [tdc_cfg_pkg::FINE_BIT-1:0]     start_fine,
    output logic [tdc_cfg_pkg::NUM_BIT-1:0]     hit_index,
    input  wire [tdc_cfg_pkg::NUM_BIT-1:0]      res_index,
    output logic [tdc_cfg_pkg::TOF_BIT-1:0]     result,
    output logic                                calc_done
);
    import tdc_cfg_pkg::*;

    typedef enum logic {
        CALC_IDLE,
        CALC_RUN
    } calc_state_t;

    calc_state_t        state;
    logic [TOF_BIT-1:0] res_mem [MAX_HITS];
    logic [TOF_BIT-1:0] coarse_ext;
    logic [TOF_BIT-1:0] tof;
    logic               last_hit;

    //==========================================================================
    // tof = coarse * taps + stop fine - start fine
    //==========================================================================
    assign coarse_ext = TOF_BIT'(hit.coarse);
    assign tof        = TOF_BIT'(coarse_ext * PHASE_BIT)
                      + TOF_BIT'(hit.fine)
                      - TOF_BIT'(start_fine);    // coarse >= 1, never negative

    assign last_hit = (hit_index == hit_count - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CALC_IDLE;
            hit_index <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= 1'b0;
            case (state)
                CALC_IDLE: begin
                    if (window_done) begin
                        if (hit_count == '0) begin
                            calc_done <= 1'b1;   // nothing to do
                        end else begin
                            state     <= CALC_RUN;
                            hit_index <= '0;
                        end
                    end
                end
                CALC_RUN: begin
                    if (last_hit) begin
                        state     <= CALC_IDLE;
                        hit_index <= '0;
                        calc_done <= 1'b1;
                    end else begin
                        hit_index <= hit_index + 1'b1;
                    end
                end
                default: state <= CALC_IDLE;
            endcase
        end
    end

    // result i lands in slot i
    always_ff @(posedge clk) begin
        if (state == CALC_RUN) begin
            res_mem[hit_index] <= tof;
        end
    end

    assign result = res_mem[res_index];

endmodule : tof_calc

`default_nettype wire
